// ==== bench/tb_checks.svh ====
// Testbench helpers for the serial link loopback
// LFSR, expected message and frame builders, compare tasks, stimulus table

`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// One stimulus row together with the rx message expected from each channel
typedef struct packed {
  logic               en0;
  logic               en1;
  msg_pkg::msg_data_t d0;
  msg_pkg::msg_data_t d1;
  msg_pkg::msg_strb_t s0;
  msg_pkg::msg_strb_t s1;
  logic [7:0]         rx_pat;
  msg_pkg::msg_t      exp0;
  msg_pkg::msg_t      exp1;
} row_t;

// Rows in the order they are applied
row_t table_q[$];

////////////////////////////////////////////////////////////
// Random bits

// Fibonacci LFSR x^16 + x^14 + x^13 + x^11 + 1 stepped once per bit taken
function automatic logic lfsr_bit();
  logic out;
  out    = lfsr_q[15];
  lfsr_q = {lfsr_q[14:0], lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10]};
  return out;
endfunction

function automatic logic [15:0] rand_bits(input int n);
  logic [15:0] v;
  v = '0;
  for (int i = 0; i < n; i++) begin
    v = {v[14:0], lfsr_bit()};
  end
  return v;
endfunction

////////////////////////////////////////////////////////////
// Expected values

// A message as it comes back with a byte past the strobe run read as zero
function automatic msg_pkg::msg_t expect_msg(input msg_pkg::chan_e ch,
                                             input msg_pkg::msg_data_t d,
                                             input msg_pkg::msg_strb_t s);
  msg_pkg::msg_t m;
  m.chan = ch;
  m.strb = (s == 2'b11) ? 2'b11 : 2'b01;
  m.data = (s == 2'b11) ? d : {8'h00, d[7:0]};
  return m;
endfunction

function automatic row_t make_row(input logic e0, input logic e1,
                                  input msg_pkg::msg_data_t d0, input msg_pkg::msg_data_t d1,
                                  input msg_pkg::msg_strb_t s0, input msg_pkg::msg_strb_t s1,
                                  input logic [7:0] pat);
  row_t r;
  r.en0    = e0;
  r.en1    = e1;
  r.d0     = d0;
  r.d1     = d1;
  r.s0     = s0;
  r.s1     = s1;
  r.rx_pat = pat;
  r.exp0   = expect_msg(msg_pkg::CHAN_0, d0, s0);
  r.exp1   = expect_msg(msg_pkg::CHAN_1, d1, s1);
  return r;
endfunction

// Places a message at block occ with channel and length bits first and then
// the payload low bit first. Only the first block gets the control bit
function automatic void place_msg(inout frame_pkg::frame_t f, inout int occ,
                                  input msg_pkg::msg_t m);
  logic [19:0] img;
  int          nblk;
  img      = '0;
  img[0]   = m.chan;
  img[1]   = (m.strb == 2'b11);
  img[9:2] = m.data[7:0];
  nblk     = 3;
  if (m.strb == 2'b11) begin
    img[17:10] = m.data[15:8];
    nblk       = 5;
  end
  for (int b = 0; b < nblk; b++) begin
    f[occ + b].data = img[4*b +: 4];
    f[occ + b].ctrl = (b == 0);
  end
  occ = occ + nblk;
endfunction

////////////////////////////////////////////////////////////
// Compare tasks

task automatic check_msg(input string name, input msg_pkg::msg_t exp,
                         input msg_pkg::msg_t act);
  if (act !== exp) begin
    errors++;
    $display("CHECK FAILED %s: expected %h, actual %h at %0t", name, exp, act, $time);
  end
endtask

task automatic check_frame(input string name, input frame_pkg::frame_t exp,
                           input frame_pkg::frame_t act);
  if (act !== exp) begin
    errors++;
    $display("CHECK FAILED %s: expected %h, actual %h at %0t", name, exp, act, $time);
  end
endtask

task automatic check_bit(input string name, input logic exp, input logic act);
  if (act !== exp) begin
    errors++;
    $display("CHECK FAILED %s: expected %h, actual %h at %0t", name, exp, act, $time);
  end
endtask

////////////////////////////////////////////////////////////
// Stimulus table

task automatic build_table();
  logic               e0;
  logic               e1;
  msg_pkg::msg_data_t d0;
  msg_pkg::msg_data_t d1;
  msg_pkg::msg_strb_t s0;
  msg_pkg::msg_strb_t s1;
  logic [15:0]        v;
  // Both channels request straight after reset and channel 0 must win first
  table_q.push_back(make_row(1'b1, 1'b1, 16'h1234, 16'hBEEF, 2'b11, 2'b01, 8'hFF));
  // Single messages where the byte past a one-byte strobe comes back as zero
  table_q.push_back(make_row(1'b0, 1'b1, 16'h0000, 16'hA5C3, 2'b00, 2'b01, 8'hFF));
  table_q.push_back(make_row(1'b1, 1'b0, 16'h3C5A, 16'h0000, 2'b11, 2'b00, 8'hFF));
  // Here the pointer favours channel 1
  table_q.push_back(make_row(1'b1, 1'b1, 16'h0F0F, 16'hF00D, 2'b01, 2'b11, 8'h55));
  table_q.push_back(make_row(1'b1, 1'b1, 16'h7E81, 16'h0042, 2'b11, 2'b11, 8'hFF));
  repeat (30) begin
    e0 = lfsr_bit();
    e1 = lfsr_bit();
    d0 = rand_bits(16);
    d1 = rand_bits(16);
    s0 = lfsr_bit() ? 2'b11 : 2'b01;
    s1 = lfsr_bit() ? 2'b11 : 2'b01;
    v  = rand_bits(8);
    // Bit 0 is forced so that every pattern lets some traffic through
    table_q.push_back(make_row(e0, e1, d0, d1, s0, s1, v[7:0] | 8'h01));
  end
endtask

`endif

// ==== bench/tb_serial_loopback.sv ====
// Testbench for the serial link loopback
// Clock, reset, DUT, table loop, lane frame and back-pressure tests, scoreboard

`timescale 1ns/100ps
`default_nettype none

module tb_serial_loopback;

  localparam int ROW_TIMEOUT   = 200;
  localparam int DRAIN_TIMEOUT = 600;
  localparam int STALL_TIMEOUT = 300;

  logic               clk_i;
  logic               rst_n_i;
  logic               ch0_valid_i;
  logic               ch0_ready_o;
  msg_pkg::msg_data_t ch0_data_i;
  msg_pkg::msg_strb_t ch0_strb_i;
  logic               ch1_valid_i;
  logic               ch1_ready_o;
  msg_pkg::msg_data_t ch1_data_i;
  msg_pkg::msg_strb_t ch1_strb_i;
  logic               rx_valid_o;
  logic               rx_ready_i;
  msg_pkg::msg_data_t rx_data_o;
  msg_pkg::msg_strb_t rx_strb_o;
  msg_pkg::chan_e     rx_chan_o;
  logic               link_valid_o;
  frame_pkg::frame_t  link_frame_o;

  int                errors    = 0;
  int                timeouts  = 0;
  logic [15:0]       lfsr_q    = 16'd9;
  logic [7:0]        rx_pat    = 8'hFF;
  logic [2:0]        rx_phase  = '0;
  logic              link_prev = 1'b0;
  // Model of the arbiter's priority pointer
  msg_pkg::chan_e    ptr_model = msg_pkg::CHAN_0;
  msg_pkg::msg_t     exp0_cur;
  msg_pkg::msg_t     exp1_cur;
  msg_pkg::msg_t     exp_q[$];
  frame_pkg::frame_t lane_q[$];

  `include "tb_checks.svh"

  serial_loopback_top serial_loopback_top_inst (.*);

  initial begin
    clk_i = 1'b0;
    forever #10 clk_i = ~clk_i;
  end

  // rx_ready follows the current row's pattern at one bit per cycle
  initial begin : rx_driver
    logic nxt;
    forever begin
      @(posedge clk_i);
      nxt      = rx_pat[rx_phase];
      rx_phase = rx_phase + 1'b1;
      #2;
      rx_ready_i = nxt;
    end
  end

  ////////////////////////////////////////////////////////////
  // Scoreboard

  // Values sampled at the falling edge are the ones the next rising edge sees
  always @(negedge clk_i) begin : scoreboard
    msg_pkg::chan_e pred;
    msg_pkg::msg_t  got;
    if (rst_n_i) begin
      if (ch0_valid_i || ch1_valid_i) begin
        if (ch0_valid_i && ch1_valid_i) begin
          pred = ptr_model;
        end else begin
          pred = ch1_valid_i ? msg_pkg::CHAN_1 : msg_pkg::CHAN_0;
        end
        // The channel that lost the grant must not see ready
        if (pred == msg_pkg::CHAN_0) begin
          check_bit("ch1_ready_o", 1'b0, ch1_ready_o);
        end else begin
          check_bit("ch0_ready_o", 1'b0, ch0_ready_o);
        end
        if ((pred == msg_pkg::CHAN_0) ? ch0_ready_o : ch1_ready_o) begin
          exp_q.push_back((pred == msg_pkg::CHAN_0) ? exp0_cur : exp1_cur);
          ptr_model = (pred == msg_pkg::CHAN_0) ? msg_pkg::CHAN_1 : msg_pkg::CHAN_0;
        end
      end
      if (rx_valid_o && rx_ready_i) begin
        got = '{data: rx_data_o, strb: rx_strb_o, chan: rx_chan_o};
        if (exp_q.size() == 0) begin
          errors++;
          $display("rx delivered a message that was never sent at %0t", $time);
        end else begin
          check_msg("rx message", exp_q.pop_front(), got);
        end
      end
      // A new frame enters the lane on each rise of link_valid_o
      if (link_valid_o && !link_prev) begin
        lane_q.push_back(link_frame_o);
      end
      link_prev = link_valid_o;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus tasks are entered and left 2 ns after a rising edge

  task automatic apply_row(input row_t r);
    logic p0;
    logic p1;
    int   cyc;
    p0         = r.en0;
    p1         = r.en1;
    rx_pat     = r.rx_pat;
    exp0_cur   = r.exp0;
    exp1_cur   = r.exp1;
    ch0_data_i = r.d0;
    ch0_strb_i = r.s0;
    ch1_data_i = r.d1;
    ch1_strb_i = r.s1;
    cyc        = 0;
    while ((p0 || p1) && cyc < ROW_TIMEOUT) begin
      ch0_valid_i = p0;
      ch1_valid_i = p1;
      @(negedge clk_i);
      p0 = p0 & ~ch0_ready_o;
      p1 = p1 & ~ch1_ready_o;
      @(posedge clk_i);
      #2;
      cyc++;
    end
    ch0_valid_i = 1'b0;
    ch1_valid_i = 1'b0;
    if (p0 || p1) begin
      timeouts++;
      $display("Timeout: a table row was not accepted within %0d cycles", ROW_TIMEOUT);
    end
  endtask

  task automatic wait_drain();
    int cyc;
    cyc    = 0;
    rx_pat = 8'hFF;
    @(negedge clk_i);
    while ((exp_q.size() != 0 || link_valid_o || rx_valid_o) && cyc < DRAIN_TIMEOUT) begin
      @(negedge clk_i);
      cyc++;
    end
    if (cyc >= DRAIN_TIMEOUT) begin
      timeouts++;
      $display("Timeout: the link did not drain, %0d messages outstanding", exp_q.size());
    end
    @(posedge clk_i);
    #2;
  endtask

  // A 2-byte message fills one frame and two 1-byte messages share the next one
  task automatic frame_test();
    frame_pkg::frame_t exp_f;
    row_t              a;
    row_t              b;
    row_t              c;
    int                occ;
    int                cyc;
    wait_drain();
    lane_q.delete();
    a = make_row(1'b1, 1'b0, 16'h9A7B, 16'h0000, 2'b11, 2'b00, 8'hFF);
    b = make_row(1'b0, 1'b1, 16'h0000, 16'h5E44, 2'b00, 2'b01, 8'hFF);
    c = make_row(1'b1, 1'b0, 16'hFF21, 16'h0000, 2'b01, 2'b00, 8'hFF);
    apply_row(a);
    apply_row(b);
    apply_row(c);
    cyc = 0;
    while (lane_q.size() < 2 && cyc < ROW_TIMEOUT) begin
      @(negedge clk_i);
      cyc++;
    end
    if (lane_q.size() < 2) begin
      timeouts++;
      $display("Timeout: fewer than two frames crossed the lane");
    end else begin
      exp_f = '0;
      occ   = 0;
      place_msg(exp_f, occ, a.exp0);
      check_frame("link_frame_o first frame", exp_f, lane_q[0]);
      exp_f = '0;
      occ   = 0;
      place_msg(exp_f, occ, b.exp1);
      place_msg(exp_f, occ, c.exp0);
      check_frame("link_frame_o", exp_f, lane_q[1]);
    end
    @(posedge clk_i);
    #2;
  endtask

  // Hold rx_ready low until channel 0 stays blocked and then release
  task automatic stall_test();
    logic [7:0] k;
    int         low_run;
    int         cyc;
    wait_drain();
    rx_pat      = 8'h00;
    k           = 8'h00;
    low_run     = 0;
    cyc         = 0;
    ch0_valid_i = 1'b1;
    while (low_run < 16 && cyc < STALL_TIMEOUT) begin
      ch0_data_i = {k, 8'h5A ^ k};
      ch0_strb_i = k[0] ? 2'b01 : 2'b11;
      exp0_cur   = expect_msg(msg_pkg::CHAN_0, ch0_data_i, ch0_strb_i);
      @(negedge clk_i);
      if (ch0_ready_o) begin
        low_run = 0;
        k       = k + 1'b1;
      end else begin
        low_run++;
      end
      @(posedge clk_i);
      #2;
      cyc++;
    end
    if (low_run < 16) begin
      timeouts++;
      $display("Timeout: channel 0 ready never stayed low under rx back-pressure");
    end
    // The held message stays on the channel until the pipeline frees up
    apply_row(make_row(1'b1, 1'b0, ch0_data_i, 16'h0000, ch0_strb_i, 2'b00, 8'hFF));
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence

  initial begin : main
    rst_n_i     = 1'b0;
    ch0_valid_i = 1'b0;
    ch0_data_i  = '0;
    ch0_strb_i  = '0;
    ch1_valid_i = 1'b0;
    ch1_data_i  = '0;
    ch1_strb_i  = '0;
    rx_ready_i  = 1'b0;
    repeat (3) @(posedge clk_i);
    @(negedge clk_i);
    check_bit("rx_valid_o", 1'b0, rx_valid_o);
    check_bit("link_valid_o", 1'b0, link_valid_o);
    check_bit("ch0_ready_o", 1'b0, ch0_ready_o);
    check_bit("ch1_ready_o", 1'b0, ch1_ready_o);
    @(posedge clk_i);
    #2;
    rst_n_i = 1'b1;
    build_table();
    foreach (table_q[i]) begin
      apply_row(table_q[i]);
    end
    frame_test();
    stall_test();
    wait_drain();
    if (exp_q.size() != 0) begin
      errors++;
      $display("Scoreboard still holds %0d messages at the end", exp_q.size());
    end
    $display("Errors: %0d, timeouts: %0d", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== common/frame_pkg.sv ====
// Link-side definitions: block and frame layout, link timing and FSM states

`default_nettype none

package frame_pkg;

  // Payload bits per block, the control bit comes on top
  localparam int BLOCK_DATA_BITS = 4;
  // Channel and length bits at the start of every message
  localparam int HDR_BITS        = 2;
  localparam int NUM_BLOCKS      = 6;
  // Cycles the lane stays occupied by one frame
  localparam int LINK_CLK_DIV    = 4;

  // Blocks per message: header plus payload, rounded up to whole blocks
  localparam int MSG_BLOCKS_1B = (8 + HDR_BITS + BLOCK_DATA_BITS - 1) / BLOCK_DATA_BITS;
  localparam int MSG_BLOCKS_2B =
      (8*msg_pkg::MSG_BYTES + HDR_BITS + BLOCK_DATA_BITS - 1) / BLOCK_DATA_BITS;

  typedef struct packed {
    logic [BLOCK_DATA_BITS-1:0] data;
    logic                       ctrl;
  } block_t;

  typedef block_t [NUM_BLOCKS-1:0] frame_t;

  typedef logic [$clog2(NUM_BLOCKS+1)-1:0] block_cnt_t;

  // Flat bit image of the largest message, header in the lowest bits
  typedef logic [MSG_BLOCKS_2B*BLOCK_DATA_BITS-1:0] msg_bits_t;

  // Occupancy counter of the lane model
  typedef logic [$clog2(LINK_CLK_DIV+1)-1:0] link_cnt_t;

  typedef enum logic {PACK_EMPTY, PACK_OPEN} pack_state_e;
  typedef enum logic {UNP_IDLE, UNP_EMIT} unpack_state_e;

endpackage

`default_nettype wire

// ==== common/msg_pkg.sv ====
// Message-side definitions shared by the channels, arbiter, packer and unpacker
// Payload, strobe and channel types and the message struct

`default_nettype none

package msg_pkg;

  // Largest message in bytes
  localparam int MSG_BYTES = 2;

  // Payload of one message, byte 0 in the low bits
  typedef logic [8*MSG_BYTES-1:0] msg_data_t;

  // Byte strobe; only the run of ones starting at bit 0 counts
  typedef logic [MSG_BYTES-1:0] msg_strb_t;

  // Number of valid bytes, zero up to MSG_BYTES
  typedef logic [$clog2(MSG_BYTES+1)-1:0] msg_cnt_t;

  // Source channel of a message
  typedef enum logic {
    CHAN_0 = 1'b0,
    CHAN_1 = 1'b1
  } chan_e;

  // One message as it travels on a stream, 19 bits
  typedef struct packed {
    msg_data_t data;
    msg_strb_t strb;
    chan_e     chan;
  } msg_t;

endpackage

`default_nettype wire

// ==== common/msg_stream_if.sv ====
// Valid/ready message stream with source and sink views

`timescale 1ns/100ps
`default_nettype none

interface msg_stream_if;

  // A transfer takes place on a rising edge with valid and ready both high
  logic          valid;
  logic          ready;
  msg_pkg::msg_t msg;

  // Producer side holds valid and msg stable until the transfer
  modport src (
    output valid,
    output msg,
    input  ready
  );

  // Consumer side
  modport snk (
    input  valid,
    input  msg,
    output ready
  );

endinterface

`default_nettype wire

// ==== dequeue/dequeue_register.sv ====
// Frame unpacker that finds message starts by control bits
// Replays the messages of one frame in order under back-pressure

`timescale 1ns/100ps
`default_nettype none

module dequeue_register (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              frame_valid_i,
  output logic              frame_ready_o,
  input  frame_pkg::frame_t frame_i,
  msg_stream_if.src         msg_o
);

  frame_pkg::unpack_state_e state_q;
  frame_pkg::frame_t        frame_q;
  // Start block of the message currently on the output
  frame_pkg::block_cnt_t    ptr_q;
  frame_pkg::block_cnt_t    msg_blocks;
  frame_pkg::msg_bits_t     msg_bits;
  msg_pkg::msg_t            out_msg;
  logic [7:0]               start_vec;
  logic [3:0]               next_ptr;
  logic                     len_bit;
  logic                     more;

  assign frame_ready_o = (state_q == frame_pkg::UNP_IDLE);

  ////////////////////////////////////////////////////////////
  // Message extraction

  // Gather the blocks from the pointer on, past the frame end reads zero
  always_comb begin : gather
    logic [3:0] pos;
    msg_bits = '0;
    for (int i = 0; i < frame_pkg::MSG_BLOCKS_2B; i++) begin
      pos = {1'b0, ptr_q} + 4'(i);
      if (pos < 4'(frame_pkg::NUM_BLOCKS)) begin
        msg_bits[frame_pkg::BLOCK_DATA_BITS*i +: frame_pkg::BLOCK_DATA_BITS] =
            frame_q[pos[2:0]].data;
      end
    end
  end

  assign len_bit = msg_bits[1];

  // The second byte may hold the next message, so it is cut by the length bit
  always_comb begin
    out_msg.chan = msg_pkg::chan_e'(msg_bits[0]);
    out_msg.data = msg_bits[frame_pkg::HDR_BITS +: $bits(msg_pkg::msg_data_t)];
    out_msg.strb = len_bit ? 2'b11 : 2'b01;
    if (!len_bit) begin
      out_msg.data[8 +: 8] = 8'h00;
    end
  end

  assign msg_o.valid = (state_q == frame_pkg::UNP_EMIT);
  assign msg_o.msg   = out_msg;

  ////////////////////////////////////////////////////////////
  // Block pointer

  // Control bits padded to a power of two so any pointer value reads safely
  always_comb begin
    start_vec = '0;
    for (int b = 0; b < frame_pkg::NUM_BLOCKS; b++) begin
      start_vec[b] = frame_q[b].ctrl;
    end
  end

  assign msg_blocks = len_bit ? frame_pkg::block_cnt_t'(frame_pkg::MSG_BLOCKS_2B)
                              : frame_pkg::block_cnt_t'(frame_pkg::MSG_BLOCKS_1B);
  assign next_ptr   = {1'b0, ptr_q} + {1'b0, msg_blocks};
  // Another message follows only if the next block is a start block
  assign more       = (next_ptr < 4'(frame_pkg::NUM_BLOCKS)) & start_vec[next_ptr[2:0]];

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= frame_pkg::UNP_IDLE;
      ptr_q   <= '0;
    end else if (frame_valid_i && frame_ready_o) begin
      state_q <= frame_pkg::UNP_EMIT;
      ptr_q   <= '0;
    end else if (msg_o.valid && msg_o.ready) begin
      if (more) begin
        ptr_q <= next_ptr[2:0];
      end else begin
        state_q <= frame_pkg::UNP_IDLE;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (frame_valid_i && frame_ready_o) begin
      frame_q <= frame_i;
    end
  end

endmodule

`default_nettype wire

// ==== enqueue/enqueue_register.sv ====
// Block counter for a message strobe
// Frame packer that collects messages into blocks with control bits

`timescale 1ns/100ps
`default_nettype none

module block_count (
  input  msg_pkg::msg_strb_t    strb_i,
  output msg_pkg::msg_cnt_t     bytes_o,
  output frame_pkg::block_cnt_t blocks_o
);

  msg_pkg::msg_cnt_t bytes;

  // Count the ones from bit 0 up, the first zero ends the run
  always_comb begin : count_ones
    logic run;
    run   = 1'b1;
    bytes = '0;
    for (int i = 0; i < msg_pkg::MSG_BYTES; i++) begin
      run   = run & strb_i[i];
      bytes = bytes + msg_pkg::msg_cnt_t'(run);
    end
  end

  assign bytes_o  = bytes;
  // Eight bits per byte plus the header, rounded up to whole blocks
  assign blocks_o = frame_pkg::block_cnt_t'(
      (8*int'(bytes) + frame_pkg::HDR_BITS + frame_pkg::BLOCK_DATA_BITS - 1)
      / frame_pkg::BLOCK_DATA_BITS);

endmodule


module enqueue_register (
  input  logic              clk_i,
  input  logic              rst_n_i,
  msg_stream_if.snk         msg_i,
  output logic              frame_valid_o,
  input  logic              frame_ready_i,
  output frame_pkg::frame_t frame_o
);

  frame_pkg::pack_state_e state_q, state_d;
  frame_pkg::block_cnt_t  occ_q, occ_d;
  frame_pkg::frame_t      frame_q, frame_d;
  frame_pkg::block_cnt_t  req_blocks;
  frame_pkg::block_cnt_t  idx;
  frame_pkg::msg_bits_t   msg_bits;
  msg_pkg::msg_cnt_t      msg_bytes;
  msg_pkg::msg_data_t     masked_data;
  logic [3:0]             end_blk;
  logic                   en_q;
  logic                   len_bit;
  logic                   fits, full;
  logic                   accept, handover;

  block_count block_count_inst (
    .strb_i   (msg_i.msg.strb),
    .bytes_o  (msg_bytes),
    .blocks_o (req_blocks)
  );

  ////////////////////////////////////////////////////////////
  // Acceptance and offer

  // First block past the pending message if it were placed now
  assign end_blk = {1'b0, occ_q} + {1'b0, req_blocks};
  assign fits    = (end_blk <= 4'(frame_pkg::NUM_BLOCKS));
  assign full    = (occ_q == frame_pkg::block_cnt_t'(frame_pkg::NUM_BLOCKS));

  // An empty frame takes anything, an open one only what still fits.
  // en_q holds the stream off until the first cycle out of reset
  assign msg_i.ready = en_q & ((state_q == frame_pkg::PACK_EMPTY) | fits);

  // The frame goes out as soon as waiting longer gains nothing.
  // While the pacer is busy it stays open and keeps collecting
  assign frame_valid_o = (state_q == frame_pkg::PACK_OPEN) &
                         (~msg_i.valid | ~fits | full);

  assign accept   = msg_i.valid & msg_i.ready;
  assign handover = frame_valid_o & frame_ready_i;

  ////////////////////////////////////////////////////////////
  // Message bit image

  // Bytes outside the strobe run go out as zero
  always_comb begin
    for (int i = 0; i < msg_pkg::MSG_BYTES; i++) begin
      masked_data[8*i +: 8] = (int'(msg_bytes) > i) ? msg_i.msg.data[8*i +: 8] : 8'h00;
    end
  end

  assign len_bit = (msg_bytes == msg_pkg::msg_cnt_t'(msg_pkg::MSG_BYTES));

  // Channel at bit 0, length at bit 1, then the payload low bit first
  always_comb begin
    msg_bits    = '0;
    msg_bits[0] = msg_i.msg.chan;
    msg_bits[1] = len_bit;
    msg_bits[frame_pkg::HDR_BITS +: $bits(msg_pkg::msg_data_t)] = masked_data;
  end

  ////////////////////////////////////////////////////////////
  // Frame and counter update

  // A message fills blocks occ_q up to end_blk - 1, control bit on the first one
  always_comb begin
    frame_d = frame_q;
    idx     = '0;
    if (handover) begin
      frame_d = '0;
    end else if (accept) begin
      for (int b = 0; b < frame_pkg::NUM_BLOCKS; b++) begin
        if ((4'(b) >= {1'b0, occ_q}) && (4'(b) < end_blk)) begin
          idx             = frame_pkg::block_cnt_t'(4'(b) - {1'b0, occ_q});
          frame_d[b].data = msg_bits[frame_pkg::BLOCK_DATA_BITS*idx +: frame_pkg::BLOCK_DATA_BITS];
          frame_d[b].ctrl = (idx == '0);
        end
      end
    end
  end

  // Accept and handover never fall in the same cycle
  always_comb begin
    state_d = state_q;
    occ_d   = occ_q;
    if (handover) begin
      state_d = frame_pkg::PACK_EMPTY;
      occ_d   = '0;
    end else if (accept) begin
      state_d = frame_pkg::PACK_OPEN;
      occ_d   = end_blk[2:0];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      en_q    <= 1'b0;
      state_q <= frame_pkg::PACK_EMPTY;
      occ_q   <= '0;
      frame_q <= '0;
    end else begin
      en_q    <= 1'b1;
      state_q <= state_d;
      occ_q   <= occ_d;
      frame_q <= frame_d;
    end
  end

  assign frame_o = frame_q;

endmodule

`default_nettype wire

// ==== serial_loopback.f ====
+incdir+bench
common/msg_pkg.sv
common/frame_pkg.sv
common/msg_stream_if.sv
src/msg_arbiter.sv
enqueue/enqueue_register.sv
src/link_pacer.sv
dequeue/dequeue_register.sv
src/serial_loopback_top.sv
bench/tb_serial_loopback.sv

// ==== src/link_pacer.sv ====
// Model of the slow physical lane
// Holds each frame for LINK_CLK_DIV cycles before passing it on

`timescale 1ns/100ps
`default_nettype none

module link_pacer (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              frame_valid_i,
  output logic              frame_ready_o,
  input  frame_pkg::frame_t frame_i,
  output logic              frame_valid_o,
  input  logic              frame_ready_i,
  output frame_pkg::frame_t frame_o,
  output logic              lane_busy_o
);

  logic                 busy_q;
  frame_pkg::link_cnt_t cnt_q;
  frame_pkg::frame_t    frame_q;

  // A new frame only enters an idle lane
  assign frame_ready_o = ~busy_q;

  // The frame leaves once the occupancy time has run out
  assign frame_valid_o = busy_q & (cnt_q == '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      busy_q <= 1'b0;
      cnt_q  <= '0;
    end else if (frame_valid_i && !busy_q) begin
      busy_q <= 1'b1;
      cnt_q  <= frame_pkg::link_cnt_t'(frame_pkg::LINK_CLK_DIV);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end else if (frame_valid_o && frame_ready_i) begin
      busy_q <= 1'b0;
    end
  end

  // Lane content, only meaningful while busy
  always_ff @(posedge clk_i) begin
    if (frame_valid_i && !busy_q) begin
      frame_q <= frame_i;
    end
  end

  assign frame_o     = frame_q;
  // Busy also covers the wait for the unpacker
  assign lane_busy_o = busy_q;

endmodule

`default_nettype wire

// ==== src/msg_arbiter.sv ====
// Round-robin arbiter that merges the two channel streams into one
// Combinational grant with a registered priority pointer

`timescale 1ns/100ps
`default_nettype none

module msg_arbiter (
  input  logic      clk_i,
  input  logic      rst_n_i,
  msg_stream_if.snk ch0_i,
  msg_stream_if.snk ch1_i,
  msg_stream_if.src out_o
);

  // Channel that wins when both request
  msg_pkg::chan_e ptr_q;
  msg_pkg::chan_e grant;
  msg_pkg::msg_t  sel_msg;
  logic           xfer;

  ////////////////////////////////////////////////////////////
  // Grant

  // A lone requester always wins, a tie goes to the pointer
  always_comb begin
    if (ch0_i.valid && ch1_i.valid) begin
      grant = ptr_q;
    end else if (ch1_i.valid) begin
      grant = msg_pkg::CHAN_1;
    end else begin
      grant = msg_pkg::CHAN_0;
    end
  end

  // The channel tag comes from the grant and not from the source
  always_comb begin
    sel_msg      = (grant == msg_pkg::CHAN_1) ? ch1_i.msg : ch0_i.msg;
    sel_msg.chan = grant;
  end

  assign out_o.valid = ch0_i.valid | ch1_i.valid;
  assign out_o.msg   = sel_msg;

  // Only the granted channel sees the downstream ready
  assign ch0_i.ready = out_o.ready & (grant == msg_pkg::CHAN_0);
  assign ch1_i.ready = out_o.ready & (grant == msg_pkg::CHAN_1);

  assign xfer = out_o.valid & out_o.ready;

  ////////////////////////////////////////////////////////////
  // Priority pointer

  // After each transfer the other channel gets priority
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      ptr_q <= msg_pkg::CHAN_0;
    end else if (xfer) begin
      ptr_q <= (grant == msg_pkg::CHAN_0) ? msg_pkg::CHAN_1 : msg_pkg::CHAN_0;
    end
  end

endmodule

`default_nettype wire

// ==== src/serial_loopback_top.sv ====
// Top level of the serial link loopback
// Channel ports, arbiter, packer, lane model and unpacker

`timescale 1ns/100ps
`default_nettype none

module serial_loopback_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               ch0_valid_i,
  output logic               ch0_ready_o,
  input  msg_pkg::msg_data_t ch0_data_i,
  input  msg_pkg::msg_strb_t ch0_strb_i,
  input  logic               ch1_valid_i,
  output logic               ch1_ready_o,
  input  msg_pkg::msg_data_t ch1_data_i,
  input  msg_pkg::msg_strb_t ch1_strb_i,
  output logic               rx_valid_o,
  input  logic               rx_ready_i,
  output msg_pkg::msg_data_t rx_data_o,
  output msg_pkg::msg_strb_t rx_strb_o,
  output msg_pkg::chan_e     rx_chan_o,
  output logic               link_valid_o,
  output frame_pkg::frame_t  link_frame_o
);

  msg_stream_if ch0_if ();
  msg_stream_if ch1_if ();
  msg_stream_if arb_if ();
  msg_stream_if rx_if ();

  logic              pack_valid, pack_ready;
  frame_pkg::frame_t pack_frame;
  logic              lane_valid, lane_ready;
  frame_pkg::frame_t lane_frame;

  ////////////////////////////////////////////////////////////
  // Channel wrapping

  // The arbiter overwrites the tag, CHAN_x here only keeps the field defined
  assign ch0_if.valid = ch0_valid_i;
  assign ch0_if.msg   = '{data: ch0_data_i, strb: ch0_strb_i, chan: msg_pkg::CHAN_0};
  assign ch0_ready_o  = ch0_if.ready;

  assign ch1_if.valid = ch1_valid_i;
  assign ch1_if.msg   = '{data: ch1_data_i, strb: ch1_strb_i, chan: msg_pkg::CHAN_1};
  assign ch1_ready_o  = ch1_if.ready;

  ////////////////////////////////////////////////////////////
  // Datapath

  msg_arbiter msg_arbiter_inst (
    .clk_i   (clk_i),
    .rst_n_i (rst_n_i),
    .ch0_i   (ch0_if.snk),
    .ch1_i   (ch1_if.snk),
    .out_o   (arb_if.src)
  );

  enqueue_register enqueue_register_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .msg_i         (arb_if.snk),
    .frame_valid_o (pack_valid),
    .frame_ready_i (pack_ready),
    .frame_o       (pack_frame)
  );

  link_pacer link_pacer_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .frame_valid_i (pack_valid),
    .frame_ready_o (pack_ready),
    .frame_i       (pack_frame),
    .frame_valid_o (lane_valid),
    .frame_ready_i (lane_ready),
    .frame_o       (lane_frame),
    .lane_busy_o   (link_valid_o)
  );

  dequeue_register dequeue_register_inst (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .frame_valid_i (lane_valid),
    .frame_ready_o (lane_ready),
    .frame_i       (lane_frame),
    .msg_o         (rx_if.src)
  );

  // Lane monitor and output stream
  assign link_frame_o = lane_frame;
  assign rx_valid_o   = rx_if.valid;
  assign rx_if.ready  = rx_ready_i;
  assign rx_data_o    = rx_if.msg.data;
  assign rx_strb_o    = rx_if.msg.strb;
  assign rx_chan_o    = rx_if.msg.chan;

endmodule

`default_nettype wire
